// File: src/calc_defs.svh
//********************
// Sizes shared by the keypad calculator
// Operands are two decimal digits, results up to 9801
// SCAN_DWELL is a cycle count, no separate display clock
//********************
`ifndef CALC_DEFS_SVH
`define CALC_DEFS_SVH

// Keypad matrix
`define KEY_ROWS 4
`define KEY_COLS 4

// Display
`define DIGITS 4
`define SEG_W 7
`define SCAN_DWELL 4 // Cycles each digit stays lit

// Data widths
`define OPERAND_W 7 // 0 to 99
`define RESULT_W 14 // Up to 99 x 99
`define BCD_W 16 // Four packed BCD digits

`endif

// File: src/calc_pkg.sv
//********************
// Types of the keypad calculator
// Key codes hold the digit value for keys 0 to 9
//********************
`default_nettype none

`include "calc_defs.svh"

package calc_pkg;

    typedef enum logic [3:0] {
        key_0   = 4'd0,
        key_1   = 4'd1,
        key_2   = 4'd2,
        key_3   = 4'd3,
        key_4   = 4'd4,
        key_5   = 4'd5,
        key_6   = 4'd6,
        key_7   = 4'd7,
        key_8   = 4'd8,
        key_9   = 4'd9,
        key_add = 4'd10, // A
        key_mul = 4'd11, // B
        key_equ = 4'd12, // C
        key_clr = 4'd13, // D
        key_e   = 4'd14,
        key_f   = 4'd15
    } key_code_t;

    typedef enum logic [2:0] {
        st_tens_a, st_units_a, st_op, st_tens_b, st_units_b, st_equ, st_busy, st_show
    } entry_state_t;

    typedef enum logic {op_add, op_mul} arith_op_t;

    typedef logic [`OPERAND_W-1:0] operand_t;
    typedef logic [`RESULT_W-1:0] result_t;
    typedef logic [`BCD_W-1:0] bcd_t; // Units digit in the low nibble
    typedef logic [`SEG_W-1:0] seg_t; // Active low, gfedcba

endpackage

`default_nettype wire

// File: src/keypad_scan.sv
//********************
// Matrix keypad scanner, one row per cycle
// Columns must be clean, there is no debouncer
// A new key needs a full idle scan after the last one
//********************
`timescale 1ns/10ps
`default_nettype none

`include "calc_defs.svh"

module keypad_scan import calc_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`KEY_COLS-1:0] col,
    output logic [`KEY_ROWS-1:0] row,
    output logic                 key_strobe,
    output key_code_t            key_code
);

    localparam int ROW_IDX_W = $clog2(`KEY_ROWS);
    localparam int COL_IDX_W = $clog2(`KEY_COLS);
    localparam int IDLE_W = $clog2(`KEY_ROWS + 1);

    // Layout, row by row from the left column
    localparam key_code_t KEY_MAP [`KEY_ROWS][`KEY_COLS] = '{
        '{key_1, key_2, key_3, key_add},
        '{key_4, key_5, key_6, key_mul},
        '{key_7, key_8, key_9, key_equ},
        '{key_e, key_0, key_f, key_clr}
    };

    logic [ROW_IDX_W-1:0] row_idx;
    logic [COL_IDX_W-1:0] col_idx;
    logic [IDLE_W-1:0] idle_cnt; // Consecutive cycles with no column high
    logic released;
    logic accept;

    always_comb begin
        row_idx = '0;
        col_idx = '0;
        for (int i = 0; i < `KEY_ROWS; i++) begin
            if (row[i]) row_idx = ROW_IDX_W'(i);
        end
        // Downward so the lowest column wins
        for (int j = `KEY_COLS - 1; j >= 0; j--) begin
            if (col[j]) col_idx = COL_IDX_W'(j);
        end
    end

    assign accept = released && (col != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            row <= {{(`KEY_ROWS - 1){1'b0}}, 1'b1};
            idle_cnt <= '0;
            released <= 1'b0;
            key_strobe <= 1'b0;
        end else begin
            row <= {row[`KEY_ROWS-2:0], row[`KEY_ROWS-1]}; // Ring
            key_strobe <= accept;
            if (col != '0) begin
                idle_cnt <= '0;
            end else if (idle_cnt != IDLE_W'(`KEY_ROWS)) begin
                idle_cnt <= idle_cnt + IDLE_W'(1);
            end
            if (accept) begin
                released <= 1'b0;
            end else if (idle_cnt == IDLE_W'(`KEY_ROWS)) begin
                released <= 1'b1; // Full scan seen with nothing pressed
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) key_code <= KEY_MAP[row_idx][col_idx];
    end

endmodule

`default_nettype wire

// File: src/entry_sequencer.sv
//********************
// Entry FSM for two 2-digit operands, operator and equals
// Out-of-sequence keys are ignored, all keys dropped while busy
//********************
`timescale 1ns/10ps
`default_nettype none

module entry_sequencer import calc_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      key_strobe,
    input  key_code_t key_code,
    input  logic      arith_done,
    input  result_t   arith_result,
    output logic      arith_start,
    output operand_t  operand_a,
    output operand_t  operand_b,
    output arith_op_t op,
    output result_t   disp_value
);

    entry_state_t state;
    logic digit_key;
    operand_t digit_val;
    operand_t digit_tens;

    assign digit_key = key_strobe && (key_code <= key_9);
    assign digit_val = operand_t'(key_code);
    assign digit_tens = (digit_val << 3) + (digit_val << 1); // x10

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_tens_a;
            operand_a <= '0;
            operand_b <= '0;
            op <= op_add;
            arith_start <= 1'b0;
        end else begin
            arith_start <= 1'b0;
            if (key_strobe && key_code == key_clr && state != st_busy) begin
                state <= st_tens_a;
                operand_a <= '0;
                operand_b <= '0;
            end else begin
                case (state)
                    st_tens_a, st_show: begin
                        if (digit_key) begin // Fresh entry
                            operand_a <= digit_tens;
                            operand_b <= '0;
                            state <= st_units_a;
                        end
                    end
                    st_units_a: begin
                        if (digit_key) begin
                            operand_a <= operand_a + digit_val;
                            state <= st_op;
                        end
                    end
                    st_op: begin
                        if (key_strobe && (key_code == key_add || key_code == key_mul)) begin
                            op <= (key_code == key_mul) ? op_mul : op_add;
                            state <= st_tens_b;
                        end
                    end
                    st_tens_b: begin
                        if (digit_key) begin
                            operand_b <= digit_tens;
                            state <= st_units_b;
                        end
                    end
                    st_units_b: begin
                        if (digit_key) begin
                            operand_b <= operand_b + digit_val;
                            state <= st_equ;
                        end
                    end
                    st_equ: begin
                        if (key_strobe && key_code == key_equ) begin
                            arith_start <= 1'b1;
                            state <= st_busy;
                        end
                    end
                    st_busy: if (arith_done) state <= st_show;
                    default: state <= st_tens_a;
                endcase
            end
        end
    end

    // Operand A until B gets its first digit
    always_comb begin
        case (state)
            st_units_b, st_equ, st_busy: disp_value = result_t'(operand_b);
            st_show: disp_value = arith_result;
            default: disp_value = result_t'(operand_a);
        endcase
    end

endmodule

`default_nettype wire

// File: src/arith_unit.sv
//********************
// Add in one cycle, multiply by repeated addition
// Multiply takes operand_b + 1 cycles to done
// Result held until the next start
//********************
`timescale 1ns/10ps
`default_nettype none

module arith_unit import calc_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  operand_t  operand_a,
    input  operand_t  operand_b,
    input  arith_op_t op,
    output logic      done,
    output logic      busy,
    output result_t   result
);

    operand_t mcand;
    operand_t mplier;
    operand_t count; // Additions done so far
    result_t acc;
    logic run;

    assign busy = run | start; // Includes the start cycle

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run <= 1'b0;
            done <= 1'b0;
            count <= '0;
            mcand <= '0;
            mplier <= '0;
            acc <= '0;
            result <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                mcand <= operand_a;
                mplier <= operand_b;
                count <= '0;
                acc <= '0;
                if (op == op_add) begin
                    result <= result_t'(operand_a) + result_t'(operand_b);
                    done <= 1'b1;
                end else if (operand_b == '0) begin
                    result <= '0; // Nothing to add
                    done <= 1'b1;
                end else begin
                    run <= 1'b1;
                end
            end else if (run) begin
                acc <= acc + result_t'(mcand);
                count <= count + operand_t'(1);
                // Latch together with the last addition
                if (count == mplier - operand_t'(1)) begin
                    result <= acc + result_t'(mcand);
                    done <= 1'b1;
                    run <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/bcd_converter.sv
//********************
// Free-running double dabble, 17 cycles per pass
// A new value shows on bcd within two passes
//********************
`timescale 1ns/10ps
`default_nettype none

`include "calc_defs.svh"

module bcd_converter import calc_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  result_t value,
    output bcd_t    bcd
);

    localparam int STEPS = `BCD_W;
    localparam int SR_W = 2 * `BCD_W; // BCD half over binary half
    localparam int PAD_W = SR_W - `RESULT_W;
    localparam int CNT_W = $clog2(STEPS + 1);

    logic [SR_W-1:0] shift_reg;
    logic [SR_W-1:0] adjusted;
    logic [SR_W-1:0] shifted;
    logic [CNT_W-1:0] step; // 0 loads, then one shift per step

    always_comb begin
        adjusted = shift_reg;
        for (int j = 0; j < `DIGITS; j++) begin
            if (adjusted[`BCD_W + 4*j +: 4] >= 4'd5) begin
                adjusted[`BCD_W + 4*j +: 4] = adjusted[`BCD_W + 4*j +: 4] + 4'd3;
            end
        end
    end

    assign shifted = {adjusted[SR_W-2:0], 1'b0};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            step <= '0;
            bcd <= '0;
        end else if (step == CNT_W'(STEPS)) begin
            bcd <= shifted[SR_W-1 -: `BCD_W]; // Publish and restart
            step <= '0;
        end else begin
            step <= step + CNT_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (step == '0) begin
            shift_reg <= {{PAD_W{1'b0}}, value};
        end else begin
            shift_reg <= shifted;
        end
    end

endmodule

`default_nettype wire

// File: src/display_mux.sv
//********************
// Four-digit seven-segment multiplexer
// Anodes and segments active low, digit 0 first
//********************
`timescale 1ns/10ps
`default_nettype none

`include "calc_defs.svh"

module display_mux import calc_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  bcd_t               bcd,
    output seg_t               seg,
    output logic [`DIGITS-1:0] an
);

    localparam int NUM_DIGITS = `DIGITS;
    localparam int IDX_W = $clog2(NUM_DIGITS);
    localparam int DWELL_W = $clog2(`SCAN_DWELL);

    logic [DWELL_W-1:0] dwell_cnt;
    logic [IDX_W-1:0] digit_idx;
    logic [3:0] nibble;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dwell_cnt <= '0;
            digit_idx <= '0;
        end else if (dwell_cnt == DWELL_W'(`SCAN_DWELL - 1)) begin
            dwell_cnt <= '0;
            digit_idx <= (digit_idx == IDX_W'(NUM_DIGITS - 1)) ? '0 : digit_idx + IDX_W'(1);
        end else begin
            dwell_cnt <= dwell_cnt + DWELL_W'(1);
        end
    end

    assign nibble = bcd[digit_idx*4 +: 4];

    always_comb begin
        for (int i = 0; i < NUM_DIGITS; i++) begin
            an[i] = (digit_idx != IDX_W'(i));
        end
    end

    //********************
    // Hex glyphs, gfedcba
    always_comb begin
        case (nibble)
            4'h0: seg = 7'b1000000;
            4'h1: seg = 7'b1111001;
            4'h2: seg = 7'b0100100;
            4'h3: seg = 7'b0110000;
            4'h4: seg = 7'b0011001;
            4'h5: seg = 7'b0010010;
            4'h6: seg = 7'b0000010;
            4'h7: seg = 7'b1111000;
            4'h8: seg = 7'b0000000;
            4'h9: seg = 7'b0011000;
            4'ha: seg = 7'b0001000;
            4'hb: seg = 7'b0000011;
            4'hc: seg = 7'b1000110;
            4'hd: seg = 7'b0100001;
            4'he: seg = 7'b0000110;
            4'hf: seg = 7'b0001110;
        endcase
    end

endmodule

`default_nettype wire

// File: src/calc_top.sv
//********************
// Keypad calculator top, A adds, B multiplies, C equals, D clears
// col must be driven from row, active high
//********************
`timescale 1ns/10ps
`default_nettype none

`include "calc_defs.svh"

module calc_top import calc_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`KEY_COLS-1:0] col,
    output logic [`KEY_ROWS-1:0] row,
    output seg_t                 seg,
    output logic [`DIGITS-1:0]   an
);

    logic key_strobe;
    key_code_t key_code;
    logic arith_start;
    operand_t operand_a;
    operand_t operand_b;
    arith_op_t op;
    logic arith_done;
    logic arith_busy;
    result_t arith_result;
    result_t disp_value;
    bcd_t disp_bcd;

    //********************
    // Decode
    keypad_scan scan_i (
        .clk(clk), .rst(rst), .col(col), .row(row),
        .key_strobe(key_strobe), .key_code(key_code)
    );

    entry_sequencer seq_i (
        .clk(clk), .rst(rst), .key_strobe(key_strobe), .key_code(key_code),
        .arith_done(arith_done), .arith_result(arith_result),
        .arith_start(arith_start), .operand_a(operand_a), .operand_b(operand_b),
        .op(op), .disp_value(disp_value)
    );

    //********************
    // Execute
    arith_unit arith_i (
        .clk(clk), .rst(rst), .start(arith_start),
        .operand_a(operand_a), .operand_b(operand_b), .op(op),
        .done(arith_done), .busy(arith_busy), .result(arith_result)
    );

    //********************
    // Result
    bcd_converter bcd_i (.clk(clk), .rst(rst), .value(disp_value), .bcd(disp_bcd));

    display_mux disp_i (.clk(clk), .rst(rst), .bcd(disp_bcd), .seg(seg), .an(an));

endmodule

`default_nettype wire

// File: verification/calc_properties.sv
//********************
// Bound to calc_top, watches scan, display and arithmetic pulses
// fail_count is read by the testbench for its verdict
//********************
`timescale 1ns/10ps
`default_nettype none

`include "calc_defs.svh"

module calc_properties import calc_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`KEY_ROWS-1:0] row,
    input  logic [`DIGITS-1:0]   an,
    input  logic                 key_strobe,
    input  logic                 arith_start,
    input  logic                 arith_done,
    input  logic                 arith_busy,
    input  arith_op_t            op
);

    int fail_count = 0;

    row_one_hot: assert property (@(posedge clk) disable iff (rst) $onehot(row))
        else begin
            $error("row is not one-hot");
            fail_count++;
        end

    an_one_low: assert property (@(posedge clk) disable iff (rst) $onehot(~an))
        else begin
            $error("an does not have exactly one digit low");
            fail_count++;
        end

    // Done needs a running multiply or an add start just before
    done_after_busy: assert property (@(posedge clk) disable iff (rst)
        arith_done |-> $past(arith_busy || (arith_start && op == op_add)))
        else begin
            $error("arith_done without a preceding busy or add start");
            fail_count++;
        end

    strobe_single: assert property (@(posedge clk) disable iff (rst)
        key_strobe |=> !key_strobe)
        else begin
            $error("key_strobe high on two consecutive cycles");
            fail_count++;
        end

endmodule

bind calc_top calc_properties props_i (
    .clk(clk), .rst(rst), .row(row), .an(an), .key_strobe(key_strobe),
    .arith_start(arith_start), .arith_done(arith_done), .arith_busy(arith_busy),
    .op(op)
);

`default_nettype wire

// File: verification/calc_tb.sv
//********************
// Testbench for the keypad calculator
// Keys held 12 cycles, released 12 cycles
// Display checked only through an and seg
//********************
`timescale 1ns/10ps
`default_nettype none

`include "calc_defs.svh"

module calc_tb import calc_pkg::*; ();

    localparam int HOLD_CYCLES = 12;
    localparam int RELEASE_CYCLES = 12;
    localparam int SETTLE_CYCLES = 60;
    localparam int LONG_HOLD = 200;
    localparam int FRAME_CYCLES = `DIGITS * `SCAN_DWELL;
    localparam int KEY_PRESSES = 278;
    localparam int CHECKS = 52;
    localparam int WATCHDOG_CYCLES = KEY_PRESSES * (HOLD_CYCLES + RELEASE_CYCLES)
        + CHECKS * (SETTLE_CYCLES + 99 + FRAME_CYCLES) + LONG_HOLD + 5000;

    logic clk;
    logic rst;
    logic [`KEY_COLS-1:0] col;
    logic [`KEY_ROWS-1:0] row;
    seg_t seg;
    logic [`DIGITS-1:0] an;

    logic key_down;
    key_code_t held_key;
    logic [3:0] key_pos; // {row, col}
    int cyc;
    int seed;
    result_t exp_value;
    int settle_cycles;
    event check_go;
    event check_done;

    calc_top dut_i (.clk(clk), .rst(rst), .col(col), .row(row), .seg(seg), .an(an));

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Cycles since reset release, gives the expected scan position
    always @(posedge clk) begin
        if (rst) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    //********************
    // Keypad model
    function automatic logic [3:0] key_position(key_code_t k);
        case (k)
            key_1:   return 4'b00_00;
            key_2:   return 4'b00_01;
            key_3:   return 4'b00_10;
            key_add: return 4'b00_11;
            key_4:   return 4'b01_00;
            key_5:   return 4'b01_01;
            key_6:   return 4'b01_10;
            key_mul: return 4'b01_11;
            key_7:   return 4'b10_00;
            key_8:   return 4'b10_01;
            key_9:   return 4'b10_10;
            key_equ: return 4'b10_11;
            key_e:   return 4'b11_00;
            key_0:   return 4'b11_01;
            key_f:   return 4'b11_10;
            default: return 4'b11_11; // D
        endcase
    endfunction

    assign key_pos = key_position(held_key);

    always_comb begin
        col = '0;
        if (key_down) begin
            col[key_pos[1:0]] = row[key_pos[3:2]]; // Closed switch joins row and column
        end
    end

    //********************
    // Expected values
    function automatic result_t calc_expected(int a, int b, arith_op_t o);
        if (o == op_mul) begin
            return result_t'(a * b);
        end
        return result_t'(a + b);
    endfunction

    // Active low, gfedcba
    function automatic seg_t digit_glyph(logic [3:0] d);
        case (d)
            4'd0:    return 7'b1000000;
            4'd1:    return 7'b1111001;
            4'd2:    return 7'b0100100;
            4'd3:    return 7'b0110000;
            4'd4:    return 7'b0011001;
            4'd5:    return 7'b0010010;
            4'd6:    return 7'b0000010;
            4'd7:    return 7'b1111000;
            4'd8:    return 7'b0000000;
            4'd9:    return 7'b0011000;
            default: return 7'b1111111;
        endcase
    endfunction

    function automatic logic [3:0] decimal_digit(result_t v, int pos);
        int rest;
        rest = int'(v);
        for (int i = 0; i < pos; i++) begin
            rest = rest / 10;
        end
        return 4'(rest % 10);
    endfunction

    //********************
    // Compare tasks
    task automatic fail_now(string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_seg(seg_t got, seg_t expected, int digit);
        if (got !== expected) begin
            fail_now($sformatf("Error at %0t ns: seg on digit %0d expected %b, got %b",
                $time, digit, expected, got));
        end
    endtask

    task automatic check_an(logic [`DIGITS-1:0] got, logic [`DIGITS-1:0] expected);
        if (got !== expected) begin
            fail_now($sformatf("Error at %0t ns: an expected %b, got %b",
                $time, expected, got));
        end
    endtask

    task automatic check_row(logic [`KEY_ROWS-1:0] got, logic [`KEY_ROWS-1:0] expected);
        if (got !== expected) begin
            fail_now($sformatf("Error at %0t ns: row expected %b, got %b",
                $time, expected, got));
        end
    endtask

    //********************
    // Stimulus tasks
    task automatic press_key(key_code_t k, int hold);
        @(posedge clk);
        held_key <= k;
        key_down <= 1'b1;
        repeat (hold) @(posedge clk);
        key_down <= 1'b0;
        repeat (RELEASE_CYCLES) @(posedge clk);
    endtask

    task automatic press_digit(int d);
        press_key(key_code_t'(4'(d)), HOLD_CYCLES);
    endtask

    task automatic expect_display(result_t v, int extra);
        exp_value = v;
        settle_cycles = SETTLE_CYCLES + extra;
        -> check_go;
        @(check_done);
    endtask

    // Multiply latency grows with operand b
    task automatic run_calc(int a, int b, arith_op_t o);
        press_digit(a / 10);
        press_digit(a % 10);
        press_key((o == op_mul) ? key_mul : key_add, HOLD_CYCLES);
        press_digit(b / 10);
        press_digit(b % 10);
        press_key(key_equ, HOLD_CYCLES);
        expect_display(calc_expected(a, b, o), (o == op_mul) ? b : 0);
    endtask

    // One full display frame, sampled on falling edges
    initial begin : compare
        int digit;
        forever begin
            @(check_go);
            repeat (settle_cycles) @(posedge clk);
            for (int i = 0; i < FRAME_CYCLES; i++) begin
                @(negedge clk);
                digit = (cyc / `SCAN_DWELL) % `DIGITS;
                check_an(an, ~(`DIGITS'(1) << digit));
                check_seg(seg, digit_glyph(decimal_digit(exp_value, digit)), digit);
            end
            -> check_done;
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the test sequence did not finish within %0d cycles",
            WATCHDOG_CYCLES);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        int a;
        int b;
        int unsigned r;
        rst = 1'b1;
        key_down = 1'b0;
        held_key = key_0;
        seed = 32'h388cc656;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // Ring rotation, then a zero display
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            check_row(row, `KEY_ROWS'(1) << (cyc % `KEY_ROWS));
        end
        expect_display('0, 0);

        press_digit(4);
        press_digit(7);
        expect_display(result_t'(47), 0);
        press_key(key_clr, HOLD_CYCLES); // Back to a fresh entry
        expect_display('0, 0);

        for (int n = 0; n < 20; n++) begin
            r = $random(seed);
            a = int'(r % 100);
            r = $random(seed);
            b = int'(r % 100);
            run_calc(a, b, op_add);
        end
        for (int n = 0; n < 20; n++) begin
            r = $random(seed);
            a = int'(r % 100);
            r = $random(seed);
            b = int'(r % 100);
            run_calc(a, b, op_mul);
        end
        run_calc(0, 57, op_mul);
        run_calc(57, 0, op_mul);
        run_calc(99, 99, op_mul);

        //********************
        // Ignored and clear keys
        press_key(key_clr, HOLD_CYCLES);
        press_key(key_add, HOLD_CYCLES); // Operator before any digit
        expect_display('0, 0);
        press_digit(1);
        press_key(key_e, HOLD_CYCLES); // E and F between digits
        press_key(key_f, HOLD_CYCLES);
        press_digit(2);
        expect_display(result_t'(12), 0);
        press_key(key_mul, HOLD_CYCLES);
        press_digit(3);
        expect_display(result_t'(30), 0);
        press_key(key_clr, HOLD_CYCLES);
        expect_display('0, 0);
        run_calc(25, 31, op_mul);

        press_key(key_5, LONG_HOLD); // Must count once
        press_digit(3);
        expect_display(result_t'(53), 0);

        if (dut_i.props_i.fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+src
src/calc_pkg.sv
src/keypad_scan.sv
src/entry_sequencer.sv
src/arith_unit.sv
src/bcd_converter.sv
src/display_mux.sv
src/calc_top.sv
verification/calc_properties.sv
verification/calc_tb.sv

// File: run.sh
#!/bin/sh
# Builds the calculator testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module calc_tb -f build.f --Mdir obj_dir -o calc_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/calc_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1
